// File: src/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// architectural register file as seen by decode
`define NUM_AREG 32

// physical register pool shared by the whole core
`define NUM_PREG 64

// index widths
`define AREG_W 5
`define PREG_W 6

// rename slots per group
`define GROUP_W 2

// enough for the largest possible free count of NUM_PREG - NUM_AREG
`define FREE_CNT_W 6

`endif

// File: src/rename_pkg.sv
`include "rename_defs.svh"

package rename_pkg;

	// only alu and load ops write rd
	typedef enum logic [2:0] {
		UOP_ALU,
		UOP_LOAD,
		UOP_STORE,
		UOP_BRANCH,
		UOP_NOP
	} uop_e;

	typedef enum logic {
		ST_RUN,
		ST_FLUSH
	} ren_state_e;

	typedef struct packed {
		uop_e               op;
		logic [`AREG_W-1:0] rd;
		logic [`AREG_W-1:0] rs1;
		logic [`AREG_W-1:0] rs2;
	} dis_slot_t;

	typedef struct packed {
		logic                       valid;
		dis_slot_t [`GROUP_W-1:0]   slot;
	} dis_group_t;

	typedef struct packed {
		uop_e               op;
		logic [`PREG_W-1:0] prd;
		logic [`PREG_W-1:0] prs1;
		logic [`PREG_W-1:0] prs2;
		logic [`PREG_W-1:0] old_prd;
		logic               p1_rdy;
		logic               p2_rdy;
		logic               alloc;
	} ren_slot_t;

	typedef struct packed {
		logic                       valid;
		ren_slot_t [`GROUP_W-1:0]   slot;
	} ren_group_t;

	typedef struct packed {
		logic               valid;
		logic               alloc;
		logic [`AREG_W-1:0] rd;
		logic [`PREG_W-1:0] prd;
		logic [`PREG_W-1:0] old_prd;
	} com_slot_t;

	typedef struct packed {
		logic               valid;
		logic [`PREG_W-1:0] prd;
	} wb_slot_t;

endpackage

// File: src/rename_ctrl.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_ctrl
	import rename_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  dis_group_t             i_dis,
	input  logic                   i_flush,
	input  logic [`FREE_CNT_W-1:0] i_free_cnt,
	output logic                   o_accept,
	output logic [`GROUP_W-1:0]    o_alloc_req,
	output logic                   o_flush_go,
	output logic                   o_stall
);

	ren_state_e             state;
	logic [`FREE_CNT_W-1:0] need;

	// a slot allocates only if it really writes a register
	always_comb begin
		need = '0;
		for (int i = 0; i < `GROUP_W; i++) begin
			o_alloc_req[i] = i_dis.valid &&
				(i_dis.slot[i].op == UOP_ALU || i_dis.slot[i].op == UOP_LOAD) &&
				(i_dis.slot[i].rd != '0);
			need = need + `FREE_CNT_W'(o_alloc_req[i]);
		end
	end

	// whole group or nothing
	always_comb begin
		o_accept = i_dis.valid && (state == ST_RUN) && !i_flush &&
			(i_free_cnt >= need);
		o_stall  = i_dis.valid && !o_accept;
	end

	// tables restore at the edge of the flush pulse
	assign o_flush_go = i_flush;

	// one recovery cycle follows every flush
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_RUN;
		end else begin
			case (state)
				ST_RUN: begin
					if (i_flush)
						state <= ST_FLUSH;
				end
				ST_FLUSH: begin
					state <= i_flush ? ST_FLUSH : ST_RUN;
				end
				default: begin
					state <= ST_RUN;
				end
			endcase
		end
	end

endmodule

// File: src/free_list.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module free_list
	import rename_pkg::*;
(
	input  logic                                i_clk,
	input  logic                                i_arst_n,
	input  logic                                i_accept,
	input  logic [`GROUP_W-1:0]                 i_alloc_req,
	input  com_slot_t [`GROUP_W-1:0]            i_com,
	input  logic                                i_flush_go,
	output logic [`GROUP_W-1:0][`PREG_W-1:0]    o_alloc_prd,
	output logic [`FREE_CNT_W-1:0]              o_free_cnt
);

	logic [`PREG_W-1:0]                 fifo [`NUM_PREG];
	logic [`PREG_W-1:0]                 spec_head;
	logic [`PREG_W-1:0]                 ret_head;
	logic [`PREG_W-1:0]                 tail;
	logic [`PREG_W-1:0]                 head_p1;
	logic [`PREG_W-1:0]                 alloc_cnt;
	logic [`PREG_W-1:0]                 push_cnt;
	logic [`PREG_W-1:0]                 ret_nx;
	logic [`PREG_W-1:0]                 head_nx;
	logic [`GROUP_W-1:0]                push;
	logic [`GROUP_W-1:0][`PREG_W-1:0]   push_ptr;

	assign head_p1 = spec_head + 1'b1;

	// slot 1 takes the head entry when slot 0 does not allocate
	always_comb begin
		o_alloc_prd[0] = fifo[spec_head];
		o_alloc_prd[1] = i_alloc_req[0] ? fifo[head_p1] : fifo[spec_head];
	end

	always_comb begin
		alloc_cnt = '0;
		push_cnt  = '0;
		for (int i = 0; i < `GROUP_W; i++) begin
			push[i]     = i_com[i].valid && i_com[i].alloc;
			push_ptr[i] = tail + push_cnt;
			push_cnt    = push_cnt + `PREG_W'(push[i]);
			if (i_accept && i_alloc_req[i])
				alloc_cnt = alloc_cnt + 1'b1;
		end
		// every committed allocation retires one entry behind the head
		ret_nx  = ret_head + push_cnt;
		head_nx = i_flush_go ? ret_nx : spec_head + alloc_cnt;
	end

	assign o_free_cnt = `FREE_CNT_W'(tail - spec_head);

	// after reset the list holds the registers above the identity map
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `NUM_PREG; i++) begin
				fifo[i] <= (i < `NUM_AREG) ? `PREG_W'(i + `NUM_AREG) : '0;
			end
			spec_head <= '0;
			ret_head  <= '0;
			tail      <= `PREG_W'(`NUM_AREG);
		end else begin
			spec_head <= head_nx;
			ret_head  <= ret_nx;
			tail      <= tail + push_cnt;
			// old mappings return in commit order
			for (int i = 0; i < `GROUP_W; i++) begin
				if (push[i])
					fifo[push_ptr[i]] <= i_com[i].old_prd;
			end
		end
	end

endmodule

// File: src/map_table.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module map_table
	import rename_pkg::*;
(
	input  logic                                    i_clk,
	input  logic                                    i_arst_n,
	input  dis_group_t                              i_dis,
	input  logic                                    i_accept,
	input  logic [`GROUP_W-1:0]                     i_alloc_req,
	input  logic [`GROUP_W-1:0][`PREG_W-1:0]        i_alloc_prd,
	input  com_slot_t [`GROUP_W-1:0]                i_com,
	input  logic                                    i_flush_go,
	output ren_group_t                              o_ren_map,
	output logic [2*`GROUP_W-1:0][`PREG_W-1:0]      o_src_prs
);

	logic [`PREG_W-1:0]                 spec_map [`NUM_AREG];
	logic [`PREG_W-1:0]                 arch_map [`NUM_AREG];
	logic [`PREG_W-1:0]                 arch_nx  [`NUM_AREG];
	logic [`GROUP_W-1:0][`PREG_W-1:0]   prd;
	logic [`GROUP_W-1:0][`PREG_W-1:0]   prs1;
	logic [`GROUP_W-1:0][`PREG_W-1:0]   prs2;
	logic [`GROUP_W-1:0][`PREG_W-1:0]   old_prd;
	logic                               valid_q;
	ren_slot_t [`GROUP_W-1:0]           slot_q;

	always_comb begin
		for (int i = 0; i < `GROUP_W; i++) begin
			prd[i]     = i_alloc_req[i] ? i_alloc_prd[i] : '0;
			prs1[i]    = spec_map[i_dis.slot[i].rs1];
			prs2[i]    = spec_map[i_dis.slot[i].rs2];
			old_prd[i] = spec_map[i_dis.slot[i].rd];
		end
		// slot 1 sees the mapping slot 0 creates in the same group
		if (i_alloc_req[0]) begin
			if (i_dis.slot[1].rs1 == i_dis.slot[0].rd)
				prs1[1] = prd[0];
			if (i_dis.slot[1].rs2 == i_dis.slot[0].rd)
				prs2[1] = prd[0];
			if (i_dis.slot[1].rd == i_dis.slot[0].rd)
				old_prd[1] = prd[0];
		end
		for (int i = 0; i < `GROUP_W; i++) begin
			o_src_prs[2*i]   = prs1[i];
			o_src_prs[2*i+1] = prs2[i];
		end
	end

	// committed state including this cycle's commits
	always_comb begin
		arch_nx = arch_map;
		for (int i = 0; i < `GROUP_W; i++) begin
			if (i_com[i].valid && i_com[i].alloc)
				arch_nx[i_com[i].rd] = i_com[i].prd;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `NUM_AREG; i++) begin
				spec_map[i] <= `PREG_W'(i);
				arch_map[i] <= `PREG_W'(i);
			end
			valid_q <= 1'b0;
		end else begin
			valid_q  <= i_accept;
			arch_map <= arch_nx;
			if (i_flush_go) begin
				spec_map <= arch_nx;
			end else if (i_accept) begin
				// later slot wins on a shared rd
				for (int i = 0; i < `GROUP_W; i++) begin
					if (i_alloc_req[i])
						spec_map[i_dis.slot[i].rd] <= prd[i];
				end
			end
		end
	end

	// ready bits are filled in by the busy table
	always_ff @(posedge i_clk) begin
		if (i_accept) begin
			for (int i = 0; i < `GROUP_W; i++) begin
				slot_q[i].op      <= i_dis.slot[i].op;
				slot_q[i].prd     <= prd[i];
				slot_q[i].prs1    <= prs1[i];
				slot_q[i].prs2    <= prs2[i];
				slot_q[i].old_prd <= old_prd[i];
				slot_q[i].p1_rdy  <= 1'b0;
				slot_q[i].p2_rdy  <= 1'b0;
				slot_q[i].alloc   <= i_alloc_req[i];
			end
		end
	end

	assign o_ren_map.valid = valid_q;
	assign o_ren_map.slot  = slot_q;

endmodule

// File: src/busy_table.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module busy_table
	import rename_pkg::*;
(
	input  logic                                    i_clk,
	input  logic                                    i_arst_n,
	input  logic                                    i_accept,
	input  logic [`GROUP_W-1:0]                     i_alloc_req,
	input  logic [`GROUP_W-1:0][`PREG_W-1:0]        i_alloc_prd,
	input  logic [2*`GROUP_W-1:0][`PREG_W-1:0]      i_src_prs,
	input  wb_slot_t [`GROUP_W-1:0]                 i_wb,
	input  logic                                    i_flush_go,
	output logic [2*`GROUP_W-1:0]                   o_rdy
);

	logic [`NUM_PREG-1:0]   busy;
	logic [`NUM_PREG-1:0]   wb_clr;
	logic [`NUM_PREG-1:0]   alloc_set;
	logic [2*`GROUP_W-1:0]  rdy_d;

	always_comb begin
		wb_clr    = '0;
		alloc_set = '0;
		for (int i = 0; i < `GROUP_W; i++) begin
			if (i_wb[i].valid)
				wb_clr[i_wb[i].prd] = 1'b1;
			if (i_accept && i_alloc_req[i])
				alloc_set[i_alloc_prd[i]] = 1'b1;
		end
		// writeback in the lookup cycle counts, and so does a fresh allocation
		for (int k = 0; k < 2*`GROUP_W; k++) begin
			rdy_d[k] = !(busy[i_src_prs[k]] && !wb_clr[i_src_prs[k]]) &&
				!alloc_set[i_src_prs[k]];
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			busy <= '0;
		else if (i_flush_go)
			busy <= '0;
		else
			busy <= (busy & ~wb_clr) | alloc_set;
	end

	always_ff @(posedge i_clk) begin
		o_rdy <= rdy_d;
	end

endmodule

// File: src/rename_core.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_core
	import rename_pkg::*;
(
	input  logic                        i_clk,
	input  logic                        i_arst_n,
	input  dis_group_t                  i_dis,
	input  com_slot_t [`GROUP_W-1:0]    i_com,
	input  wb_slot_t [`GROUP_W-1:0]     i_wb,
	input  logic                        i_flush,
	output ren_group_t                  o_ren,
	output logic                        o_stall
);

	logic                                   accept;
	logic [`GROUP_W-1:0]                    alloc_req;
	logic                                   flush_go;
	logic [`FREE_CNT_W-1:0]                 free_cnt;
	logic [`GROUP_W-1:0][`PREG_W-1:0]       alloc_prd;
	logic [2*`GROUP_W-1:0][`PREG_W-1:0]     src_prs;
	logic [2*`GROUP_W-1:0]                  rdy;
	ren_group_t                             ren_map;

	rename_ctrl rename_ctrl_inst (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_dis       (i_dis),
		.i_flush     (i_flush),
		.i_free_cnt  (free_cnt),
		.o_accept    (accept),
		.o_alloc_req (alloc_req),
		.o_flush_go  (flush_go),
		.o_stall     (o_stall)
	);

	free_list free_list_inst (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_accept    (accept),
		.i_alloc_req (alloc_req),
		.i_com       (i_com),
		.i_flush_go  (flush_go),
		.o_alloc_prd (alloc_prd),
		.o_free_cnt  (free_cnt)
	);

	// source indices go to the busy table before they are registered
	map_table map_table_inst (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_dis       (i_dis),
		.i_accept    (accept),
		.i_alloc_req (alloc_req),
		.i_alloc_prd (alloc_prd),
		.i_com       (i_com),
		.i_flush_go  (flush_go),
		.o_ren_map   (ren_map),
		.o_src_prs   (src_prs)
	);

	busy_table busy_table_inst (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_accept    (accept),
		.i_alloc_req (alloc_req),
		.i_alloc_prd (alloc_prd),
		.i_src_prs   (src_prs),
		.i_wb        (i_wb),
		.i_flush_go  (flush_go),
		.o_rdy       (rdy)
	);

	// both halves are registered in the same cycle
	always_comb begin
		o_ren = ren_map;
		for (int i = 0; i < `GROUP_W; i++) begin
			o_ren.slot[i].p1_rdy = rdy[2*i];
			o_ren.slot[i].p2_rdy = rdy[2*i+1];
		end
	end

endmodule

// File: tb/rename_tb_model.svh
`ifndef RENAME_TB_MODEL_SVH
`define RENAME_TB_MODEL_SVH

// shadow of the rename state, stepped once per cycle
logic [`PREG_W-1:0] m_spec [`NUM_AREG];
logic [`PREG_W-1:0] m_arch [`NUM_AREG];
logic [`PREG_W-1:0] m_fifo [`NUM_PREG];
bit                 m_busy [`NUM_PREG];
int                 m_head;
int                 m_ret;
int                 m_tail;
bit                 m_recover;
ren_group_t         m_pend;
// in-flight allocations, oldest first
com_slot_t          rob_q [$];
logic [`PREG_W-1:0] wb_q [$];

function automatic bit writes_rd(dis_slot_t s);
	return (s.op == UOP_ALU || s.op == UOP_LOAD) && s.rd != 0;
endfunction

task automatic model_reset();
	for (int i = 0; i < `NUM_PREG; i++)
		m_fifo[i] = `PREG_W'(i + `NUM_AREG);
	for (int i = 0; i < `NUM_AREG; i++) begin
		m_spec[i] = `PREG_W'(i);
		m_arch[i] = `PREG_W'(i);
	end
	m_busy = '{default: 1'b0};
	m_head = 0;
	m_ret = 0;
	m_tail = `NUM_AREG;
	m_recover = 1'b0;
	m_pend = '0;
	rob_q.delete();
	wb_q.delete();
endtask

task automatic model_cycle(input dis_group_t dis, input com_slot_t [1:0] com,
		input wb_slot_t [1:0] wb, input logic flush, output bit acc);
	bit         wb_hit [`NUM_PREG];
	int         need;
	int         k;
	ren_group_t g;
	com_slot_t  e;
	wb_hit = '{default: 1'b0};
	need = 0;
	k = 0;
	g = '0;
	for (int i = 0; i < 2; i++) begin
		if (wb[i].valid)
			wb_hit[wb[i].prd] = 1'b1;
		need += writes_rd(dis.slot[i]);
	end
	acc = dis.valid && !m_recover && !flush && (m_tail - m_head >= need);
	g.valid = acc;
	if (acc) begin
		for (int i = 0; i < 2; i++) begin
			g.slot[i].op = dis.slot[i].op;
			g.slot[i].alloc = writes_rd(dis.slot[i]);
			g.slot[i].prs1 = m_spec[dis.slot[i].rs1];
			g.slot[i].prs2 = m_spec[dis.slot[i].rs2];
			g.slot[i].old_prd = m_spec[dis.slot[i].rd];
			g.slot[i].p1_rdy = !m_busy[g.slot[i].prs1] || wb_hit[g.slot[i].prs1];
			g.slot[i].p2_rdy = !m_busy[g.slot[i].prs2] || wb_hit[g.slot[i].prs2];
			if (g.slot[i].alloc) begin
				g.slot[i].prd = m_fifo[(m_head + k) % `NUM_PREG];
				k++;
			end
		end
		// slot 1 sees slot 0's fresh mapping, which is still busy
		if (g.slot[0].alloc && dis.slot[1].rs1 == dis.slot[0].rd) begin
			g.slot[1].prs1 = g.slot[0].prd;
			g.slot[1].p1_rdy = 1'b0;
		end
		if (g.slot[0].alloc && dis.slot[1].rs2 == dis.slot[0].rd) begin
			g.slot[1].prs2 = g.slot[0].prd;
			g.slot[1].p2_rdy = 1'b0;
		end
		if (g.slot[0].alloc && dis.slot[1].rd == dis.slot[0].rd)
			g.slot[1].old_prd = g.slot[0].prd;
	end
	for (int i = 0; i < 2; i++) begin
		if (wb[i].valid)
			m_busy[wb[i].prd] = 1'b0;
	end
	for (int i = 0; i < 2; i++) begin
		if (acc && g.slot[i].alloc) begin
			m_spec[dis.slot[i].rd] = g.slot[i].prd;
			m_busy[g.slot[i].prd] = 1'b1;
			e = '{1'b1, 1'b1, dis.slot[i].rd, g.slot[i].prd, g.slot[i].old_prd};
			rob_q.push_back(e);
			wb_q.push_back(g.slot[i].prd);
		end
	end
	// freed registers go back at the tail in commit order
	for (int i = 0; i < 2; i++) begin
		if (com[i].valid && com[i].alloc) begin
			m_arch[com[i].rd] = com[i].prd;
			m_fifo[m_tail % `NUM_PREG] = com[i].old_prd;
			m_tail++;
			m_ret++;
		end
	end
	if (flush) begin
		m_spec = m_arch;
		m_head = m_ret;
		m_busy = '{default: 1'b0};
		rob_q.delete();
		wb_q.delete();
	end else begin
		m_head += k;
	end
	m_recover = flush;
	m_pend = g;
endtask

`endif

// File: tb/rename_core_tb.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_core_tb
	import rename_pkg::*;
();

	typedef enum logic [2:0] {K_DIS, K_COM, K_WB, K_FLUSH, K_IDLE} row_kind_e;

	typedef struct packed {
		row_kind_e          kind;
		dis_group_t         dis;
		logic [3:0]         rnd;
		logic [1:0]         com_n;
		logic [1:0]         wb_n;
		logic               exp_stall;
		logic               chk_prd;
		logic [`PREG_W-1:0] exp_prd0;
		logic [`PREG_W-1:0] exp_prd1;
	} row_t;

	localparam int MAX_ROWS = 48;
	localparam int ACCEPT_TIMEOUT = 8;

	logic                i_clk;
	logic                i_arst_n;
	dis_group_t          i_dis;
	com_slot_t [1:0]     i_com;
	wb_slot_t [1:0]      i_wb;
	logic                i_flush;
	ren_group_t          o_ren;
	logic                o_stall;
	row_t                rows [MAX_ROWS];
	int                  n_rows;
	int                  seed;
	int                  checks;
	int                  errors;
	int                  row_errs;
	bit                  timed_out;
	bit                  tab_chk;
	logic [`PREG_W-1:0]  tab_prd [2];

	`include "rename_tb_model.svh"

	rename_core rename_core_inst (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_dis    (i_dis),
		.i_com    (i_com),
		.i_wb     (i_wb),
		.i_flush  (i_flush),
		.o_ren    (o_ren),
		.o_stall  (o_stall)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	function automatic dis_group_t grp(input uop_e op0, input int rd0, input int a0,
			input int b0, input uop_e op1, input int rd1, input int a1, input int b1);
		dis_group_t g;
		g.valid = 1'b1;
		g.slot[0] = '{op0, `AREG_W'(rd0), `AREG_W'(a0), `AREG_W'(b0)};
		g.slot[1] = '{op1, `AREG_W'(rd1), `AREG_W'(a1), `AREG_W'(b1)};
		return g;
	endfunction

	task automatic add_row(input row_kind_e kind, input dis_group_t dis, input logic [3:0] rnd,
			input int com_n, input int wb_n, input bit stall, input bit chk, input int p0,
			input int p1);
		rows[n_rows] = '{kind, dis, rnd, 2'(com_n), 2'(wb_n), stall, chk, 6'(p0), 6'(p1)};
		n_rows++;
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			row_errs++;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// group accepted last cycle is on o_ren now
	task automatic check_output();
		ren_slot_t got;
		ren_slot_t exp;
		string     sl;
		compare_field("o_ren.valid", o_ren.valid, m_pend.valid);
		for (int i = 0; i < 2 && m_pend.valid; i++) begin
			got = o_ren.slot[i];
			exp = m_pend.slot[i];
			sl = $sformatf("o_ren.slot[%0d]", i);
			compare_field({sl, ".op"}, got.op, exp.op);
			compare_field({sl, ".prd"}, got.prd, exp.prd);
			compare_field({sl, ".prs1"}, got.prs1, exp.prs1);
			compare_field({sl, ".prs2"}, got.prs2, exp.prs2);
			compare_field({sl, ".old_prd"}, got.old_prd, exp.old_prd);
			compare_field({sl, ".p1_rdy"}, got.p1_rdy, exp.p1_rdy);
			compare_field({sl, ".p2_rdy"}, got.p2_rdy, exp.p2_rdy);
			compare_field({sl, ".alloc"}, got.alloc, exp.alloc);
			if (tab_chk)
				compare_field({sl, ".prd"}, got.prd, tab_prd[i]);
		end
		tab_chk = 1'b0;
	endtask

	task automatic apply_cycle(input dis_group_t dis, input com_slot_t [1:0] com,
			input wb_slot_t [1:0] wb, input logic flush, output bit acc);
		@(posedge i_clk);
		i_dis <= dis;
		i_com <= com;
		i_wb <= wb;
		i_flush <= flush;
		// outputs settle by the falling edge
		@(negedge i_clk);
		check_output();
		model_cycle(dis, com, wb, flush, acc);
		compare_field("o_stall", o_stall, dis.valid && !acc);
	endtask

	task automatic run_row(input int idx);
		row_t            r;
		dis_group_t      d;
		com_slot_t [1:0] com;
		wb_slot_t [1:0]  wb;
		logic [31:0]     rv;
		bit              acc;
		int              waited;
		r = rows[idx];
		d = r.dis;
		com = '0;
		wb = '0;
		row_errs = 0;
		for (int b = 0; b < 4; b++) begin
			rv = $random(seed);
			if (r.rnd[b] && b % 2 == 0)
				d.slot[b / 2].rs1 = rv[4:0];
			else if (r.rnd[b])
				d.slot[b / 2].rs2 = rv[4:0];
		end
		for (int i = 0; i < r.com_n && rob_q.size() > 0; i++)
			com[i] = rob_q.pop_front();
		for (int i = 0; i < r.wb_n && wb_q.size() > 0; i++)
			wb[i] = '{1'b1, wb_q.pop_front()};
		if (r.kind == K_DIS && r.exp_stall) begin
			apply_cycle(d, com, wb, 1'b0, acc);
			compare_field("o_stall", o_stall, 1'b1);
		end else if (r.kind == K_DIS) begin
			acc = 1'b0;
			waited = 0;
			while (!acc && waited < ACCEPT_TIMEOUT) begin
				apply_cycle(d, com, wb, 1'b0, acc);
				com = '0;
				wb = '0;
				waited++;
			end
			if (!acc) begin
				$display("row %0d: dispatch group was never accepted", idx);
				timed_out = 1'b1;
			end
			tab_chk = r.chk_prd;
			tab_prd[0] = r.exp_prd0;
			tab_prd[1] = r.exp_prd1;
		end else begin
			apply_cycle(d, com, wb, r.kind == K_FLUSH, acc);
		end
		$display("row %0d %s: %0d mismatches", idx, r.kind.name(), row_errs);
	endtask

	task automatic build_table();
		add_row(K_DIS, grp(UOP_ALU, 1, 2, 3, UOP_ALU, 2, 4, 5), 0, 0, 0, 0, 1, 32, 33);
		// slot 1 reads slot 0, then both write x8
		add_row(K_DIS, grp(UOP_ALU, 5, 1, 6, UOP_ALU, 7, 5, 1), 0, 0, 0, 0, 1, 34, 35);
		add_row(K_DIS, grp(UOP_ALU, 8, 9, 10, UOP_ALU, 8, 8, 0), 0, 0, 0, 0, 1, 36, 37);
		add_row(K_DIS, grp(UOP_STORE, 3, 1, 2, UOP_ALU, 0, 1, 2), 0, 0, 0, 0, 1, 0, 0);
		add_row(K_DIS, grp(UOP_BRANCH, 4, 7, 8, UOP_NOP, 9, 0, 0), 0, 0, 0, 0, 1, 0, 0);
		add_row(K_WB, '0, 0, 0, 2, 0, 0, 0, 0);
		add_row(K_DIS, grp(UOP_ALU, 9, 1, 2, UOP_LOAD, 10, 5, 7), 0, 0, 0, 0, 1, 38, 39);
		// writeback lands in the reader's own cycle
		add_row(K_DIS, grp(UOP_ALU, 11, 5, 7, UOP_ALU, 12, 0, 0), 4'hc, 0, 2, 0, 1, 40, 41);
		for (int i = 0; i < 11; i++)
			add_row(K_DIS, grp(UOP_ALU, 13 + i, 0, 0, UOP_LOAD, 13 + i, 0, 0), 4'hf,
				0, 0, 0, 0, 0, 0);
		// pool is empty until two commits
		add_row(K_DIS, grp(UOP_ALU, 3, 1, 2, UOP_ALU, 4, 3, 0), 0, 0, 0, 1, 0, 0, 0);
		// stalled group stays on the bus during the commit
		add_row(K_COM, grp(UOP_ALU, 3, 1, 2, UOP_ALU, 4, 3, 0), 0, 2, 0, 0, 0, 0, 0);
		add_row(K_DIS, grp(UOP_ALU, 3, 1, 2, UOP_ALU, 4, 3, 0), 0, 0, 0, 0, 1, 1, 2);
		add_row(K_COM, '0, 0, 2, 0, 0, 0, 0, 0);
		add_row(K_FLUSH, grp(UOP_ALU, 6, 1, 2, UOP_ALU, 7, 6, 0), 0, 0, 0, 0, 0, 0, 0);
		add_row(K_DIS, grp(UOP_ALU, 1, 1, 2, UOP_ALU, 5, 5, 7), 0, 0, 0, 0, 1, 36, 37);
		for (int i = 0; i < 4; i++) begin
			add_row(K_DIS, grp(UOP_ALU, 24 + i, 0, 0, UOP_LOAD, 28 + i, 0, 0), 4'hf,
				0, 0, 0, 0, 0, 0);
			add_row(K_WB, '0, 0, 0, 1, 0, 0, 0, 0);
			add_row(K_COM, '0, 0, 1, 0, 0, 0, 0, 0);
		end
		add_row(K_IDLE, '0, 0, 0, 0, 0, 0, 0, 0);
	endtask

	initial begin
		i_arst_n = 1'b0;
		i_dis = '0;
		i_com = '0;
		i_wb = '0;
		i_flush = 1'b0;
		seed = 32'hd271;
		n_rows = 0;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		tab_chk = 1'b0;
		build_table();
		model_reset();
		repeat (2) @(posedge i_clk);
		i_arst_n <= 1'b1;
		for (int idx = 0; idx < n_rows && !timed_out; idx++)
			run_row(idx);
		$display("rows %0d, checks %0d, mismatches %0d", n_rows, checks, errors);
		if (errors == 0 && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+src
+incdir+tb
src/rename_pkg.sv
src/rename_ctrl.sv
src/free_list.sv
src/map_table.sv
src/busy_table.sv
src/rename_core.sv
tb/rename_core_tb.sv

// File: Bender.yml
package:
  name: rename_core

sources:
  - include_dirs:
      - src
    files:
      - src/rename_pkg.sv
      - src/rename_ctrl.sv
      - src/free_list.sv
      - src/map_table.sv
      - src/busy_table.sv
      - src/rename_core.sv
  - target: test
    include_dirs:
      - src
      - tb
    files:
      - tb/rename_core_tb.sv
